//--- Bender.yml
package:
  name: dispatch

sources:
  - include_dirs:
      - design
    files:
      - design/dispatch_pkg.sv
      - design/wb_if.sv
      - design/gr_file.sv
      - design/sysreg_file.sv
      - design/operand_select.sv
      - design/dispatch_latch.sv
      - design/dispatch_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - verification/dispatch_checker.sv
      - verification/dispatch_tb.sv

//--- design/dispatch_config.svh
`ifndef DISPATCH_CONFIG_SVH
`define DISPATCH_CONFIG_SVH

// Datapath widths
`define DISP_WORD_W 32
`define DISP_PTR_W 5
`define DISP_CMD_W 5

`define DISP_GR_COUNT 32

// System register numbers
`define DISP_SYSREG_CPUIDR 5'd0
`define DISP_SYSREG_TIDR 5'd2
`define DISP_SYSREG_SPR 5'd4
`define DISP_SYSREG_PSR 5'd5
`define DISP_SYSREG_PPSR 5'd11

`define DISP_CPUIDR_VALUE 32'h0001_0100

// PSR bits 6, 5 and 2 drop on interrupt entry
`define DISP_PSR_IRQ_BITS 32'h0000_0064

`endif

//--- design/dispatch_latch.sv
`timescale 1ns/1ps
`include "dispatch_config.svh"

module dispatch_latch (
	input logic iCLOCK,
	input logic inRESET,
	input logic reset_sync,
	input logic refresh,
	input logic next_lock,
	input logic in_valid,
	input logic [`DISP_CMD_W-1:0] in_cmd,
	input logic [`DISP_PTR_W-1:0] in_destination,
	input logic in_destination_sysreg,
	input logic in_writeback,
	input logic [`DISP_WORD_W-1:0] in_operand0,
	input logic [`DISP_WORD_W-1:0] in_operand1,
	input logic [`DISP_WORD_W-1:0] in_pc,
	output logic next_valid,
	output logic [`DISP_CMD_W-1:0] next_cmd,
	output logic [`DISP_PTR_W-1:0] next_destination,
	output logic next_destination_sysreg,
	output logic next_writeback,
	output logic [`DISP_WORD_W-1:0] next_source0,
	output logic [`DISP_WORD_W-1:0] next_source1,
	output logic [`DISP_WORD_W-1:0] next_pc
);
	logic valid_q;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			valid_q <= 1'b0;
			next_cmd <= '0;
			next_destination <= '0;
			next_destination_sysreg <= 1'b0;
			next_writeback <= 1'b0;
			next_source0 <= '0;
			next_source1 <= '0;
			next_pc <= '0;
		end
		else if (reset_sync || refresh) begin
			valid_q <= 1'b0;
			next_cmd <= '0;
			next_destination <= '0;
			next_destination_sysreg <= 1'b0;
			next_writeback <= 1'b0;
			next_source0 <= '0;
			next_source1 <= '0;
			next_pc <= '0;
		end
		else if (!next_lock) begin
			valid_q <= in_valid;
			next_cmd <= in_cmd;
			next_destination <= in_destination;
			next_destination_sysreg <= in_destination_sysreg;
			next_writeback <= in_writeback;
			next_source0 <= in_operand0;
			next_source1 <= in_operand1;
			next_pc <= in_pc;
		end
	end

	// Held instruction stays hidden while locked
	assign next_valid = valid_q && !next_lock;
endmodule

//--- design/dispatch_pkg.sv
`include "dispatch_config.svh"

package dispatch_pkg;

	typedef struct packed {
		logic [`DISP_WORD_W-`DISP_PTR_W-1:0] unused;
		logic [`DISP_PTR_W-1:0] ptr;
	} source1_reg_t;

	// Immediate or register pointer, chosen by the immediate flag
	typedef union packed {
		logic [`DISP_WORD_W-1:0] imm;
		source1_reg_t reg_sel;
	} source1_u;

endpackage

//--- design/dispatch_top.sv
`timescale 1ns/1ps
`include "dispatch_config.svh"

module dispatch_top (
	input logic iCLOCK,
	input logic inRESET,
	input logic reset_sync,
	input logic refresh,
	input logic set_irq_mode,
	input logic clr_irq_mode,
	input logic prev_valid,
	input logic [`DISP_CMD_W-1:0] prev_cmd,
	input logic [`DISP_PTR_W-1:0] prev_destination,
	input logic prev_destination_sysreg,
	input logic prev_writeback,
	input logic [`DISP_PTR_W-1:0] prev_source0,
	input logic prev_source0_sysreg,
	input logic [`DISP_WORD_W-1:0] prev_source1,
	input logic prev_source1_sysreg,
	input logic prev_source1_imm,
	input logic [`DISP_WORD_W-1:0] prev_pc,
	output logic prev_lock,
	output logic next_valid,
	output logic [`DISP_CMD_W-1:0] next_cmd,
	output logic [`DISP_PTR_W-1:0] next_destination,
	output logic next_destination_sysreg,
	output logic next_writeback,
	output logic [`DISP_WORD_W-1:0] next_source0,
	output logic [`DISP_WORD_W-1:0] next_source1,
	output logic [`DISP_WORD_W-1:0] next_pc,
	input logic next_lock,
	input logic wb_valid,
	input logic [`DISP_WORD_W-1:0] wb_data,
	input logic [`DISP_PTR_W-1:0] wb_destination,
	input logic wb_destination_sysreg,
	input logic wb_writeback,
	input logic wb_spr_writeback,
	input logic [`DISP_WORD_W-1:0] wb_spr,
	output logic [`DISP_WORD_W-1:0] sysreg_psr,
	output logic [`DISP_WORD_W-1:0] sysreg_ppsr,
	output logic [`DISP_WORD_W-1:0] sysreg_spr,
	output logic [`DISP_WORD_W-1:0] sysreg_tidr
);
	logic [`DISP_PTR_W-1:0] rd0_ptr;
	logic [`DISP_PTR_W-1:0] rd1_ptr;
	logic [`DISP_WORD_W-1:0] gr_rd0;
	logic [`DISP_WORD_W-1:0] gr_rd1;
	logic [`DISP_WORD_W-1:0] sr_rd0;
	logic [`DISP_WORD_W-1:0] sr_rd1;
	logic [`DISP_WORD_W-1:0] operand0;
	logic [`DISP_WORD_W-1:0] operand1;

	wb_if wb_bus ();

	assign wb_bus.valid = wb_valid;
	assign wb_bus.data = wb_data;
	assign wb_bus.destination = wb_destination;
	assign wb_bus.destination_sysreg = wb_destination_sysreg;
	assign wb_bus.writeback = wb_writeback;
	assign wb_bus.spr_writeback = wb_spr_writeback;
	assign wb_bus.spr = wb_spr;

	gr_file u_gr_file (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .reset_sync(reset_sync), .wb(wb_bus),
		.rd0_ptr(rd0_ptr), .rd1_ptr(rd1_ptr), .rd0_data(gr_rd0), .rd1_data(gr_rd1)
	);

	sysreg_file u_sysreg_file (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .reset_sync(reset_sync),
		.set_irq_mode(set_irq_mode), .clr_irq_mode(clr_irq_mode), .wb(wb_bus),
		.rd0_ptr(rd0_ptr), .rd1_ptr(rd1_ptr), .rd0_data(sr_rd0), .rd1_data(sr_rd1),
		.psr(sysreg_psr), .ppsr(sysreg_ppsr), .spr(sysreg_spr), .tidr(sysreg_tidr)
	);

	operand_select u_operand_select (
		.wb(wb_bus), .source0(prev_source0), .source0_sysreg(prev_source0_sysreg),
		.source1(prev_source1), .source1_sysreg(prev_source1_sysreg),
		.source1_imm(prev_source1_imm), .gr_rd0(gr_rd0), .gr_rd1(gr_rd1),
		.sr_rd0(sr_rd0), .sr_rd1(sr_rd1), .rd0_ptr(rd0_ptr), .rd1_ptr(rd1_ptr),
		.operand0(operand0), .operand1(operand1)
	);

	dispatch_latch u_dispatch_latch (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .reset_sync(reset_sync), .refresh(refresh),
		.next_lock(next_lock), .in_valid(prev_valid), .in_cmd(prev_cmd),
		.in_destination(prev_destination), .in_destination_sysreg(prev_destination_sysreg),
		.in_writeback(prev_writeback), .in_operand0(operand0), .in_operand1(operand1),
		.in_pc(prev_pc), .next_valid(next_valid), .next_cmd(next_cmd),
		.next_destination(next_destination),
		.next_destination_sysreg(next_destination_sysreg),
		.next_writeback(next_writeback), .next_source0(next_source0),
		.next_source1(next_source1), .next_pc(next_pc)
	);

	// Stall passes straight back to the previous stage
	assign prev_lock = next_lock;
endmodule

//--- design/gr_file.sv
`timescale 1ns/1ps
`include "dispatch_config.svh"

module gr_file (
	input logic iCLOCK,
	input logic inRESET,
	input logic reset_sync,
	wb_if.sink wb,
	input logic [`DISP_PTR_W-1:0] rd0_ptr,
	input logic [`DISP_PTR_W-1:0] rd1_ptr,
	output logic [`DISP_WORD_W-1:0] rd0_data,
	output logic [`DISP_WORD_W-1:0] rd1_data
);
	logic [`DISP_WORD_W-1:0] regs [0:`DISP_GR_COUNT-1];
	logic wr_en;

	assign wr_en = wb.valid && !wb.destination_sysreg && wb.writeback;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int i = 0; i < `DISP_GR_COUNT; i++) begin
				regs[i] <= '0;
			end
		end
		else if (reset_sync) begin
			for (int i = 0; i < `DISP_GR_COUNT; i++) begin
				regs[i] <= '0;
			end
		end
		else if (wr_en) begin
			regs[wb.destination] <= wb.data;
		end
	end

	assign rd0_data = regs[rd0_ptr];
	assign rd1_data = regs[rd1_ptr];
endmodule

//--- design/operand_select.sv
`timescale 1ns/1ps
`include "dispatch_config.svh"

module operand_select (
	wb_if.sink wb,
	input logic [`DISP_PTR_W-1:0] source0,
	input logic source0_sysreg,
	input dispatch_pkg::source1_u source1,
	input logic source1_sysreg,
	input logic source1_imm,
	input logic [`DISP_WORD_W-1:0] gr_rd0,
	input logic [`DISP_WORD_W-1:0] gr_rd1,
	input logic [`DISP_WORD_W-1:0] sr_rd0,
	input logic [`DISP_WORD_W-1:0] sr_rd1,
	output logic [`DISP_PTR_W-1:0] rd0_ptr,
	output logic [`DISP_PTR_W-1:0] rd1_ptr,
	output logic [`DISP_WORD_W-1:0] operand0,
	output logic [`DISP_WORD_W-1:0] operand1
);
	logic [`DISP_WORD_W:0] fwd0;
	logic [`DISP_WORD_W:0] fwd1;

	// Top bit flags a hit on the same-cycle write-back
	function automatic logic [`DISP_WORD_W:0] forward(
		input logic [`DISP_PTR_W-1:0] ptr,
		input logic sysreg
	);
		forward = '0;
		if (wb.valid) begin
			if (!sysreg) begin
				if (!wb.destination_sysreg && wb.destination == ptr && wb.writeback) begin
					forward = {1'b1, wb.data};
				end
			end
			else if (wb.destination_sysreg) begin
				if (ptr == `DISP_SYSREG_SPR && wb.spr_writeback) begin
					forward = {1'b1, wb.spr};
				end
				else if (wb.destination == ptr && wb.writeback) begin
					forward = {1'b1, wb.data};
				end
			end
		end
	endfunction

	assign rd0_ptr = source0;
	assign rd1_ptr = source1.reg_sel.ptr;

	always_comb begin
		fwd0 = forward(source0, source0_sysreg);
		fwd1 = forward(source1.reg_sel.ptr, source1_sysreg);
	end

	always_comb begin
		if (fwd0[`DISP_WORD_W]) begin
			operand0 = fwd0[`DISP_WORD_W-1:0];
		end
		else begin
			operand0 = source0_sysreg ? sr_rd0 : gr_rd0;
		end
		// Immediate is never replaced by forwarding
		if (source1_imm) begin
			operand1 = source1.imm;
		end
		else if (fwd1[`DISP_WORD_W]) begin
			operand1 = fwd1[`DISP_WORD_W-1:0];
		end
		else begin
			operand1 = source1_sysreg ? sr_rd1 : gr_rd1;
		end
	end
endmodule

//--- design/sysreg_file.sv
`timescale 1ns/1ps
`include "dispatch_config.svh"

module sysreg_file (
	input logic iCLOCK,
	input logic inRESET,
	input logic reset_sync,
	input logic set_irq_mode,
	input logic clr_irq_mode,
	wb_if.sink wb,
	input logic [`DISP_PTR_W-1:0] rd0_ptr,
	input logic [`DISP_PTR_W-1:0] rd1_ptr,
	output logic [`DISP_WORD_W-1:0] rd0_data,
	output logic [`DISP_WORD_W-1:0] rd1_data,
	output logic [`DISP_WORD_W-1:0] psr,
	output logic [`DISP_WORD_W-1:0] ppsr,
	output logic [`DISP_WORD_W-1:0] spr,
	output logic [`DISP_WORD_W-1:0] tidr
);
	logic wr_hit;

	assign wr_hit = wb.valid && wb.destination_sysreg && wb.writeback;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			tidr <= '0;
			spr <= '0;
			psr <= '0;
			ppsr <= '0;
		end
		else if (reset_sync) begin
			tidr <= '0;
			spr <= '0;
			psr <= '0;
			ppsr <= '0;
		end
		else begin
			if (wr_hit && wb.destination == `DISP_SYSREG_TIDR) begin
				tidr <= wb.data;
			end
			// Dedicated SPR path wins over a data write
			if (wb.valid && wb.spr_writeback) begin
				spr <= wb.spr;
			end
			else if (wr_hit && wb.destination == `DISP_SYSREG_SPR) begin
				spr <= wb.data;
			end
			if (set_irq_mode) begin
				psr <= psr & ~`DISP_PSR_IRQ_BITS;
				ppsr <= psr;
			end
			else if (clr_irq_mode) begin
				psr <= ppsr;
			end
			else begin
				if (wr_hit && wb.destination == `DISP_SYSREG_PSR) begin
					psr <= wb.data;
				end
				if (wr_hit && wb.destination == `DISP_SYSREG_PPSR) begin
					ppsr <= wb.data;
				end
			end
		end
	end

	function automatic logic [`DISP_WORD_W-1:0] read_sel(input logic [`DISP_PTR_W-1:0] ptr);
		case (ptr)
			`DISP_SYSREG_CPUIDR: read_sel = `DISP_CPUIDR_VALUE;
			`DISP_SYSREG_TIDR: read_sel = tidr;
			`DISP_SYSREG_SPR: read_sel = spr;
			`DISP_SYSREG_PSR: read_sel = psr;
			`DISP_SYSREG_PPSR: read_sel = ppsr;
			default: read_sel = '0;
		endcase
	endfunction

	always_comb begin
		rd0_data = read_sel(rd0_ptr);
		rd1_data = read_sel(rd1_ptr);
	end
endmodule

//--- design/wb_if.sv
`timescale 1ns/1ps
`include "dispatch_config.svh"

interface wb_if;
	logic valid;
	logic [`DISP_WORD_W-1:0] data;
	logic [`DISP_PTR_W-1:0] destination;
	logic destination_sysreg;
	logic writeback;
	logic spr_writeback;
	logic [`DISP_WORD_W-1:0] spr;

	modport source (
		output valid, data, destination, destination_sysreg,
		output writeback, spr_writeback, spr
	);

	modport sink (
		input valid, data, destination, destination_sysreg,
		input writeback, spr_writeback, spr
	);
endinterface

//--- src.f
+incdir+design
design/dispatch_pkg.sv
design/wb_if.sv
design/gr_file.sv
design/sysreg_file.sv
design/operand_select.sv
design/dispatch_latch.sv
design/dispatch_top.sv
verification/dispatch_checker.sv
verification/dispatch_tb.sv

//--- verification/dispatch_checker.sv
`timescale 1ns/1ps
`include "dispatch_config.svh"

module dispatch_checker (
	input logic iCLOCK,
	input logic inRESET,
	input logic reset_sync,
	input logic refresh,
	input logic next_lock,
	input logic prev_lock,
	input logic next_valid,
	input logic [`DISP_CMD_W-1:0] next_cmd,
	input logic [`DISP_PTR_W-1:0] next_destination,
	input logic next_destination_sysreg,
	input logic next_writeback,
	input logic [`DISP_WORD_W-1:0] next_source0,
	input logic [`DISP_WORD_W-1:0] next_source1,
	input logic [`DISP_WORD_W-1:0] next_pc
);
	int unsigned fail_count = 0;

	lock_hides_valid: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		next_lock |-> !next_valid)
	else begin
		fail_count++;
		$error("next_valid high while next_lock is held");
	end

	lock_passes_back: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		prev_lock == next_lock)
	else begin
		fail_count++;
		$error("prev_lock differs from next_lock");
	end

	// Locked latch holds unless a clear came in
	lock_holds_fields: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(next_lock && $past(next_lock) && !$past(refresh) && !$past(reset_sync))
		|-> $stable({next_cmd, next_destination, next_destination_sysreg, next_writeback,
			next_source0, next_source1, next_pc}))
	else begin
		fail_count++;
		$error("latched fields changed during lock");
	end
endmodule

bind dispatch_top dispatch_checker u_checker (.*);

//--- verification/dispatch_tb.sv
`timescale 1ns/1ps
`include "dispatch_config.svh"

module dispatch_tb;
	// Limit sits far above the roughly 60 cycles of all tests
	localparam int MAX_CYCLES = 400;
	localparam logic [`DISP_WORD_W-1:0] IRQ_MASK = (32'd1 << 6) | (32'd1 << 5) | (32'd1 << 2);

	logic iCLOCK, inRESET, reset_sync, refresh, set_irq_mode, clr_irq_mode;
	logic prev_valid, prev_destination_sysreg, prev_writeback, prev_lock;
	logic prev_source0_sysreg, prev_source1_sysreg, prev_source1_imm;
	logic [`DISP_CMD_W-1:0] prev_cmd, next_cmd;
	logic [`DISP_PTR_W-1:0] prev_destination, prev_source0, next_destination, wb_destination;
	dispatch_pkg::source1_u prev_source1;
	logic [`DISP_WORD_W-1:0] prev_pc, next_source0, next_source1, next_pc, wb_data, wb_spr;
	logic next_valid, next_destination_sysreg, next_writeback, next_lock;
	logic wb_valid, wb_destination_sysreg, wb_writeback, wb_spr_writeback;
	logic [`DISP_WORD_W-1:0] sysreg_psr, sysreg_ppsr, sysreg_spr, sysreg_tidr;
	logic [`DISP_WORD_W-1:0] psr_expect;
	logic [31:0] rng_state = 32'd58294;
	int unsigned errors = 0;
	int unsigned cycles = 0;

	dispatch_top uut (.*);

	initial begin
		iCLOCK = 1'b0;
		forever #50 iCLOCK = ~iCLOCK;
	end

	always @(posedge iCLOCK) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: tests still running after %0d cycles", cycles);
			$display("*** FAILED ***");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function logic [31:0] rand_word();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	function automatic dispatch_pkg::source1_u reg_src(input logic [`DISP_PTR_W-1:0] ptr);
		dispatch_pkg::source1_u s;
		s.reg_sel.unused = '0;
		s.reg_sel.ptr = ptr;
		return s;
	endfunction

	function automatic dispatch_pkg::source1_u imm_src(input logic [`DISP_WORD_W-1:0] value);
		dispatch_pkg::source1_u s;
		s.imm = value;
		return s;
	endfunction

	task automatic check_word(input string name, input logic [`DISP_WORD_W-1:0] got, exp);
		if (got !== exp) begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_ptr(input string name, input logic [`DISP_PTR_W-1:0] got, exp);
		if (got !== exp) begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_cmd(input string name, input logic [`DISP_CMD_W-1:0] got, exp);
		if (got !== exp) begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, exp);
		if (got !== exp) begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic tick();
		@(posedge iCLOCK);
		#10;
	endtask

	task automatic write_back(input logic [`DISP_PTR_W-1:0] dest, input logic sys, wr,
		input logic [`DISP_WORD_W-1:0] data, input logic spr_wr,
		input logic [`DISP_WORD_W-1:0] spr);
		wb_valid = 1'b1;
		wb_destination = dest;
		wb_destination_sysreg = sys;
		wb_writeback = wr;
		wb_data = data;
		wb_spr_writeback = spr_wr;
		wb_spr = spr;
	endtask

	task automatic clear_wb();
		{wb_valid, wb_writeback, wb_spr_writeback} = '0;
	endtask

	task automatic send(input logic [`DISP_PTR_W-1:0] src0, input logic src0_sys,
		input dispatch_pkg::source1_u src1, input logic src1_sys, src1_imm);
		logic [31:0] r;
		r = rand_word();
		prev_valid = 1'b1;
		prev_cmd = r[`DISP_CMD_W-1:0];
		prev_destination = r[9:5];
		prev_destination_sysreg = r[10];
		prev_writeback = r[11];
		prev_source0 = src0;
		prev_source0_sysreg = src0_sys;
		prev_source1 = src1;
		prev_source1_sysreg = src1_sys;
		prev_source1_imm = src1_imm;
		prev_pc = rand_word();
	endtask

	// Latched instruction must match what was sent one cycle earlier
	task automatic expect_out(input logic [`DISP_WORD_W-1:0] exp0, exp1);
		check_bit("next_valid", next_valid, 1'b1);
		check_word("next_source0", next_source0, exp0);
		check_word("next_source1", next_source1, exp1);
		check_word("next_pc", next_pc, prev_pc);
		check_cmd("next_cmd", next_cmd, prev_cmd);
		check_ptr("next_destination", next_destination, prev_destination);
		check_bit("next_destination_sysreg", next_destination_sysreg, prev_destination_sysreg);
		check_bit("next_writeback", next_writeback, prev_writeback);
		prev_valid = 1'b0;
	endtask

	task automatic dispatch(input logic [`DISP_PTR_W-1:0] src0, input logic src0_sys,
		input dispatch_pkg::source1_u src1, input logic src1_sys, src1_imm,
		input logic [`DISP_WORD_W-1:0] exp0, exp1);
		send(src0, src0_sys, src1, src1_sys, src1_imm);
		tick();
		expect_out(exp0, exp1);
	endtask

	task automatic reset_state();
		logic [`DISP_PTR_W-1:0] p;
		check_bit("next_valid", next_valid, 1'b0);
		check_word("sysreg_psr", sysreg_psr, '0);
		check_word("sysreg_ppsr", sysreg_ppsr, '0);
		check_word("sysreg_spr", sysreg_spr, '0);
		check_word("sysreg_tidr", sysreg_tidr, '0);
		for (int i = 0; i < `DISP_GR_COUNT; i++) begin
			p = i[`DISP_PTR_W-1:0];
			dispatch(p, 1'b0, reg_src(~p), 1'b0, 1'b0, '0, '0);
		end
	endtask

	task automatic gr_readback();
		logic [31:0] v, imm;
		v = rand_word();
		imm = rand_word();
		write_back(5'd7, 1'b0, 1'b1, v, 1'b0, '0);
		tick();
		clear_wb();
		dispatch(5'd7, 1'b0, imm_src(imm), 1'b0, 1'b1, v, imm);
	endtask

	task automatic forwarding();
		logic [31:0] v, w, imm;
		v = rand_word();
		w = rand_word();
		imm = {rand_word() & 32'hFFFF_FFE0} | 32'd9;
		// Immediate whose pointer field aliases the write-back target
		write_back(5'd9, 1'b0, 1'b1, v, 1'b0, '0);
		dispatch(5'd9, 1'b0, imm_src(imm), 1'b0, 1'b1, v, imm);
		write_back(5'd12, 1'b0, 1'b1, w, 1'b0, '0);
		dispatch(5'd3, 1'b0, reg_src(5'd12), 1'b0, 1'b0, '0, w);
		clear_wb();
	endtask

	task automatic sysreg_access();
		logic [31:0] t, s;
		t = rand_word();
		s = rand_word();
		psr_expect = rand_word() | IRQ_MASK;
		write_back(`DISP_SYSREG_TIDR, 1'b1, 1'b1, t, 1'b0, '0);
		tick();
		write_back(`DISP_SYSREG_PSR, 1'b1, 1'b1, psr_expect, 1'b0, '0);
		tick();
		write_back(`DISP_SYSREG_SPR, 1'b1, 1'b0, rand_word(), 1'b1, s);
		tick();
		clear_wb();
		check_word("sysreg_tidr", sysreg_tidr, t);
		check_word("sysreg_psr", sysreg_psr, psr_expect);
		check_word("sysreg_spr", sysreg_spr, s);
		check_word("sysreg_ppsr", sysreg_ppsr, '0);
		dispatch(`DISP_SYSREG_TIDR, 1'b1, reg_src(`DISP_SYSREG_SPR), 1'b1, 1'b0, t, s);
		dispatch(`DISP_SYSREG_CPUIDR, 1'b1, reg_src(`DISP_SYSREG_PSR), 1'b1, 1'b0,
			`DISP_CPUIDR_VALUE, psr_expect);
	endtask

	task automatic irq_mode_switch();
		set_irq_mode = 1'b1;
		tick();
		set_irq_mode = 1'b0;
		check_word("sysreg_psr", sysreg_psr, psr_expect & ~IRQ_MASK);
		check_word("sysreg_ppsr", sysreg_ppsr, psr_expect);
		clr_irq_mode = 1'b1;
		tick();
		clr_irq_mode = 1'b0;
		check_word("sysreg_psr", sysreg_psr, psr_expect);
	endtask

	task automatic lock_and_refresh();
		logic [31:0] a, b, a_pc;
		a = rand_word();
		b = rand_word();
		send(5'd0, 1'b0, imm_src(a), 1'b0, 1'b1);
		tick();
		a_pc = prev_pc;
		check_bit("next_valid", next_valid, 1'b1);
		next_lock = 1'b1;
		// Previous stage keeps offering the next instruction
		send(5'd0, 1'b0, imm_src(b), 1'b0, 1'b1);
		repeat (3) begin
			tick();
			check_bit("next_valid", next_valid, 1'b0);
			check_bit("prev_lock", prev_lock, 1'b1);
			check_word("next_source1", next_source1, a);
			check_word("next_pc", next_pc, a_pc);
		end
		next_lock = 1'b0;
		tick();
		expect_out('0, b);
		tick();
		check_bit("next_valid", next_valid, 1'b0);
		dispatch(5'd0, 1'b0, imm_src(a), 1'b0, 1'b1, '0, a);
		refresh = 1'b1;
		tick();
		refresh = 1'b0;
		check_bit("next_valid", next_valid, 1'b0);
		check_word("next_source1", next_source1, '0);
		check_word("next_pc", next_pc, '0);
	endtask

	initial begin
		inRESET = 1'b0;
		{reset_sync, refresh, set_irq_mode, clr_irq_mode, next_lock} = '0;
		{prev_valid, prev_cmd, prev_destination, prev_destination_sysreg, prev_writeback} = '0;
		{prev_source0, prev_source0_sysreg, prev_source1_sysreg, prev_source1_imm} = '0;
		{wb_destination, wb_destination_sysreg, wb_data, wb_spr} = '0;
		prev_source1 = '0;
		prev_pc = '0;
		psr_expect = '0;
		clear_wb();
		repeat (5) @(posedge iCLOCK);
		#10;
		inRESET = 1'b1;
		reset_state();
		gr_readback();
		forwarding();
		sysreg_access();
		irq_mode_switch();
		lock_and_refresh();
		tick();
		$display("Check errors: %0d, assertion failures: %0d", errors, uut.u_checker.fail_count);
		if (errors == 0 && uut.u_checker.fail_count == 0) begin
			$display("*** PASSED ***");
		end
		else begin
			$display("*** FAILED ***");
		end
		$finish;
	end
endmodule
